//--- hdl/ecc_ic_defs.svh
/*
  Shared widths and counts for the SECDED memory subsystem.
  N_MEM must be a power of two, since the low address bits pick the bank.
  EW is sized for 32-bit data: six Hamming bits plus one overall parity bit.
  Changing DW requires a matching EW.
*/

`ifndef ECC_IC_DEFS_SVH
`define ECC_IC_DEFS_SVH

`define N_INIT 2                             // Initiator ports
`define N_MEM  4                             // Memory banks, power of two
`define DW     32                            // Data word width
`define EW     7                             // SECDED check bits
`define CW     (`DW + `EW)                   // Stored codeword width
`define AW     8                             // Word address from initiators
`define CNT_W  16                            // Error counter width
`define PAW    4                             // Peripheral register address

`define BANK_W $clog2(`N_MEM)                // Bank select bits
`define IDX_W  (`AW - `BANK_W)               // Word index inside a bank
`define INIT_W ((`N_INIT > 1) ? $clog2(`N_INIT) : 1) // Initiator id bits

`endif

//--- hdl/ecc_ic_pkg.sv
/*
  Types shared by the crossbar, codecs, banks and error manager.
  Requests follow the TCDM convention: wen high means read.
  Codeword layout is check bits above data bits, check[EW-1] is overall parity.
*/

`include "ecc_ic_defs.svh"

package ecc_ic_pkg;

  typedef struct packed {
    logic              req;                  // Request valid, held until gnt
    logic              wen;                  // High for read
    logic [`AW-1:0]    addr;                 // Word address
    logic [`DW-1:0]    data;                 // Write data
  } tcdm_req_t;

  typedef struct packed {
    logic              gnt;                  // Same-cycle grant
    logic              r_valid;              // Read data valid, one cycle
    logic [`DW-1:0]    r_data;               // Corrected read data
  } tcdm_rsp_t;

  typedef struct packed {
    logic              req;                  // One cycle per grant
    logic              wen;                  // High for read
    logic [`IDX_W-1:0] index;                // Word inside the bank
    logic [`DW-1:0]    data;                 // Raw write data
  } bank_req_t;

  typedef struct packed {
    logic [`EW-1:0]    check;                // Hamming bits plus overall parity
    logic [`DW-1:0]    data;                 // Payload
  } codeword_fields_t;

  // Same word seen as fields or as one vector
  typedef union packed {
    codeword_fields_t  fields;               // Encode and decode view
    logic [`CW-1:0]    flat;                 // Bit flip and position view
  } codeword_u;

  typedef struct packed {
    logic               en;                  // Injection active
    logic [`BANK_W-1:0] bank;                // Target bank
    logic [`CW-1:0]     mask;                // Bits to flip on write
  } fault_t;

  typedef struct packed {
    logic corr;                              // Single error fixed
    logic uncorr;                            // Double error seen
  } ecc_err_t;

  typedef struct packed {
    logic              req;                  // Always accepted
    logic              wen;                  // Low clears the counter
    logic [`PAW-1:0]   addr;                 // Counter select
  } periph_req_t;

  typedef struct packed {
    logic              r_valid;              // One cycle after req
    logic [`CNT_W-1:0] r_data;               // Counter value, zero on clear
  } periph_rsp_t;

endpackage

//--- hdl/ecc_log_xbar.sv
/*
  Logarithmic crossbar, word interleaved over N_MEM banks.
  Grants are combinational in the request cycle; losers keep req held.
  Read data returns exactly one cycle after the grant, writes end at grant.
  An initiator must not change its request while waiting for gnt.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_log_xbar (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ecc_ic_pkg::tcdm_req_t init_req_i  [`N_INIT],
  output ecc_ic_pkg::tcdm_rsp_t init_rsp_o  [`N_INIT],
  output ecc_ic_pkg::bank_req_t bank_req_o  [`N_MEM],
  input  logic [`DW-1:0]        bank_rdata_i [`N_MEM]
);
  import ecc_ic_pkg::*;

  logic [`BANK_W-1:0] init_bank [`N_INIT];   // Bank targeted by each initiator
  logic [`INIT_W-1:0] rr_q      [`N_MEM];    // Round-robin start per bank
  logic [`INIT_W-1:0] winner    [`N_MEM];    // Granted initiator per bank
  logic [`N_MEM-1:0]  found;                 // Bank has a winner this cycle
  logic [`N_INIT-1:0] gnt;                   // Per-initiator grant
  logic [`N_INIT-1:0] rvalid_q;              // Read granted last cycle
  logic [`BANK_W-1:0] rbank_q   [`N_INIT];   // Bank to return data from

  for (genvar n = 0; n < `N_INIT; n++) begin : g_split
    assign init_bank[n] = init_req_i[n].addr[`BANK_W-1:0]; // Low bits interleave
  end

  // Search from the pointer upward, first requester wins
  always_comb begin
    int cand;
    cand = 0;
    for (int b = 0; b < `N_MEM; b++) begin
      found[b]  = 1'b0;
      winner[b] = '0;
      for (int k = 0; k < `N_INIT; k++) begin
        cand = (int'(rr_q[b]) + k) % `N_INIT;
        if (!found[b] && init_req_i[cand].req && init_bank[cand] == `BANK_W'(b)) begin
          found[b]  = 1'b1;
          winner[b] = `INIT_W'(cand);
        end
      end
    end
  end

  always_comb begin
    gnt = '0;
    for (int b = 0; b < `N_MEM; b++) begin
      if (found[b]) gnt[winner[b]] = 1'b1;   // Each initiator targets one bank
      bank_req_o[b].req   = found[b];
      bank_req_o[b].wen   = init_req_i[winner[b]].wen;
      bank_req_o[b].index = init_req_i[winner[b]].addr[`AW-1:`BANK_W];
      bank_req_o[b].data  = init_req_i[winner[b]].data;
    end
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int b = 0; b < `N_MEM; b++) rr_q[b] <= '0;
      rvalid_q <= '0;
    end else begin
      for (int b = 0; b < `N_MEM; b++) begin
        if (found[b]) begin
          rr_q[b] <= (winner[b] == `INIT_W'(`N_INIT - 1)) ? '0 : winner[b] + 1'b1;
        end
      end
      for (int n = 0; n < `N_INIT; n++) rvalid_q[n] <= gnt[n] & init_req_i[n].wen;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int n = 0; n < `N_INIT; n++) begin
      if (gnt[n]) rbank_q[n] <= init_bank[n]; // Remember source bank of the read
    end
  end

  for (genvar n = 0; n < `N_INIT; n++) begin : g_rsp
    assign init_rsp_o[n].gnt     = gnt[n];
    assign init_rsp_o[n].r_valid = rvalid_q[n];
    assign init_rsp_o[n].r_data  = bank_rdata_i[rbank_q[n]]; // Decoded bank output

    a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      gnt[n] |-> init_req_i[n].req);

    for (genvar m = n + 1; m < `N_INIT; m++) begin : g_pair
      a_one_per_bank: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(gnt[n] && gnt[m] && init_bank[n] == init_bank[m]));
    end
  end

endmodule

//--- hdl/ecc_bank_codec.sv
/*
  SECDED codec in front of one bank, Hamming (38,32) plus overall parity.
  Full-word writes only, so no read-modify-write is done.
  Decode is combinational on the registered SRAM output; strobes fire only
  in the cycle after a read request. Multi-bit errors beyond two may be
  reported as correctable, as with any SECDED code.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_bank_codec #(
  parameter int unsigned BANK_ID = 0         // Matched against fault_i.bank
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  ecc_ic_pkg::bank_req_t bank_req_i,
  input  ecc_ic_pkg::fault_t    fault_i,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [`IDX_W-1:0]     mem_index_o,
  output ecc_ic_pkg::codeword_u mem_wdata_o,
  input  ecc_ic_pkg::codeword_u mem_rdata_i,
  output logic [`DW-1:0]        rdata_o,
  output ecc_ic_pkg::ecc_err_t  err_o
);
  import ecc_ic_pkg::*;

  localparam int unsigned SW = `EW - 1;      // Syndrome bits

  logic           rd_pend_q;                 // Read issued last cycle
  logic           inj_hit;                   // Fault applies to this write
  logic [SW-1:0]  enc_syn;
  logic [SW-1:0]  dec_syn;
  logic           dec_par;                   // Odd overall parity
  logic [`CW-1:0] flip;                      // One-hot correction mask
  logic           single_ok;
  codeword_u      enc_cw;
  codeword_u      fix_cw;

  // Hamming position of a flat codeword bit, zero for the overall parity
  function automatic logic [SW-1:0] ham_pos(input int b);
    logic [SW-1:0] pos;
    int            seen;
    pos  = '0;
    seen = 0;
    if (b >= `DW) begin
      if (b - `DW < SW) pos = SW'(1 << (b - `DW)); // Check bits at powers of two
    end else begin
      for (int p = 3; p < (1 << SW); p++) begin
        if ((p & (p - 1)) != 0) begin        // Skip power-of-two slots
          if (seen == b) pos = SW'(p);
          seen++;
        end
      end
    end
    return pos;
  endfunction

  // XOR of positions of all set bits
  function automatic logic [SW-1:0] syndrome(input logic [`CW-1:0] v);
    logic [SW-1:0] s;
    s = '0;
    for (int b = 0; b < `CW; b++) begin
      if (v[b]) s ^= ham_pos(b);
    end
    return s;
  endfunction

  assign enc_syn            = syndrome({{`EW{1'b0}}, bank_req_i.data}); // Check bits zeroed
  assign enc_cw.fields.data  = bank_req_i.data;
  assign enc_cw.fields.check = {^{enc_syn, bank_req_i.data}, enc_syn}; // Even total parity

  assign inj_hit = fault_i.en && fault_i.bank == `BANK_W'(BANK_ID) &&
                   bank_req_i.req && !bank_req_i.wen;

  assign mem_req_o        = bank_req_i.req;
  assign mem_we_o         = bank_req_i.req & ~bank_req_i.wen;
  assign mem_index_o      = bank_req_i.index;
  assign mem_wdata_o.flat = enc_cw.flat ^ (inj_hit ? fault_i.mask : '0);

  always_comb begin
    dec_syn = syndrome(mem_rdata_i.flat);
    dec_par = ^mem_rdata_i.flat;
    for (int b = 0; b < `CW; b++) begin
      flip[b] = dec_par && dec_syn != '0 && ham_pos(b) == dec_syn;
    end
    fix_cw.flat = mem_rdata_i.flat ^ flip;
  end

  // Odd parity with a valid or zero syndrome is a single error
  assign single_ok    = dec_par && (dec_syn == '0 || |flip);
  assign rdata_o      = fix_cw.fields.data;
  assign err_o.corr   = rd_pend_q && single_ok;
  assign err_o.uncorr = rd_pend_q && !single_ok && (dec_par || dec_syn != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) rd_pend_q <= 1'b0;
    else           rd_pend_q <= bank_req_i.req & bank_req_i.wen;
  end

  a_err_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(err_o.corr && err_o.uncorr));

endmodule

//--- hdl/ecc_sram_bank.sv
/*
  Single-port codeword storage with a registered read output.
  Read data appears one cycle after a read request and holds until the next.
  Contents are undefined after power-up.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_sram_bank (
  input  logic                  clk_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  logic [`IDX_W-1:0]     index_i,
  input  ecc_ic_pkg::codeword_u wdata_i,
  output ecc_ic_pkg::codeword_u rdata_o
);
  import ecc_ic_pkg::*;

  localparam int unsigned DEPTH = 1 << `IDX_W; // Words per bank

  codeword_u mem_q [DEPTH];                  // Storage array
  codeword_u rdata_q;                        // Output register

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[index_i] <= wdata_i;           // Full codeword write
      end else begin
        rdata_q <= mem_q[index_i];           // Read lands next cycle
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hdl/ecc_err_manager.sv
/*
  Error counters, two per bank, saturating at all ones.
  Register map: 0..N_MEM-1 correctable, N_MEM..2*N_MEM-1 uncorrectable.
  Port is always ready; a read answers next cycle, a write clears and
  answers zero. A clear beats a strobe in the same cycle.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_err_manager (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  ecc_ic_pkg::ecc_err_t    err_i [`N_MEM],
  input  ecc_ic_pkg::periph_req_t periph_req_i,
  output ecc_ic_pkg::periph_rsp_t periph_rsp_o
);
  import ecc_ic_pkg::*;

  logic [`CNT_W-1:0]  corr_q [`N_MEM];       // Correctable count per bank
  logic [`CNT_W-1:0]  unc_q  [`N_MEM];       // Uncorrectable count per bank
  logic [`BANK_W-1:0] reg_bank;
  logic               reg_unc;               // Upper half of the map
  logic               clr;
  periph_rsp_t        rsp_q;

  assign reg_bank = periph_req_i.addr[`BANK_W-1:0];
  assign reg_unc  = periph_req_i.addr[`BANK_W];
  assign clr      = periph_req_i.req && !periph_req_i.wen;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int b = 0; b < `N_MEM; b++) begin
        corr_q[b] <= '0;
        unc_q[b]  <= '0;
      end
    end else begin
      for (int b = 0; b < `N_MEM; b++) begin
        if (clr && !reg_unc && reg_bank == `BANK_W'(b)) begin
          corr_q[b] <= '0;
        end else if (err_i[b].corr && corr_q[b] != '1) begin
          corr_q[b] <= corr_q[b] + 1'b1;     // Stop at max
        end
        if (clr && reg_unc && reg_bank == `BANK_W'(b)) begin
          unc_q[b] <= '0;
        end else if (err_i[b].uncorr && unc_q[b] != '1) begin
          unc_q[b] <= unc_q[b] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.r_valid <= periph_req_i.req;
      rsp_q.r_data  <= '0;                   // Zero on clear or idle
      if (periph_req_i.req && periph_req_i.wen) begin
        rsp_q.r_data <= reg_unc ? unc_q[reg_bank] : corr_q[reg_bank];
      end
    end
  end

  assign periph_rsp_o = rsp_q;

  a_addr_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    periph_req_i.req |-> periph_req_i.addr < `PAW'(2 * `N_MEM));

endmodule

//--- hdl/ecc_interconnect.sv
/*
  Top level: crossbar, one codec and SRAM per bank, error manager.
  Read latency is one cycle from grant, writes complete at grant.
  fault_i is a level input applied to every write granted while set.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_interconnect (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  ecc_ic_pkg::tcdm_req_t   init_req_i [`N_INIT],
  output ecc_ic_pkg::tcdm_rsp_t   init_rsp_o [`N_INIT],
  input  ecc_ic_pkg::fault_t      fault_i,
  input  ecc_ic_pkg::periph_req_t periph_req_i,
  output ecc_ic_pkg::periph_rsp_t periph_rsp_o
);
  import ecc_ic_pkg::*;

  bank_req_t         bank_req   [`N_MEM];    // Crossbar to codec
  logic [`DW-1:0]    bank_rdata [`N_MEM];    // Decoded read data
  ecc_err_t          bank_err   [`N_MEM];    // Error strobes to manager
  logic [`N_MEM-1:0] mem_req;
  logic [`N_MEM-1:0] mem_we;
  logic [`IDX_W-1:0] mem_index  [`N_MEM];
  codeword_u         mem_wdata  [`N_MEM];
  codeword_u         mem_rdata  [`N_MEM];

  ecc_log_xbar i_xbar (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .init_req_i   ( init_req_i ),
    .init_rsp_o   ( init_rsp_o ),
    .bank_req_o   ( bank_req   ),
    .bank_rdata_i ( bank_rdata )
  );

  for (genvar b = 0; b < `N_MEM; b++) begin : g_bank
    ecc_bank_codec #(
      .BANK_ID ( b )
    ) i_codec (
      .clk_i       ( clk_i         ),
      .arst_n_i    ( arst_n_i      ),
      .bank_req_i  ( bank_req[b]   ),
      .fault_i     ( fault_i       ),
      .mem_req_o   ( mem_req[b]    ),
      .mem_we_o    ( mem_we[b]     ),
      .mem_index_o ( mem_index[b]  ),
      .mem_wdata_o ( mem_wdata[b]  ),
      .mem_rdata_i ( mem_rdata[b]  ),
      .rdata_o     ( bank_rdata[b] ),
      .err_o       ( bank_err[b]   )
    );

    ecc_sram_bank i_sram (
      .clk_i   ( clk_i        ),
      .req_i   ( mem_req[b]   ),
      .we_i    ( mem_we[b]    ),
      .index_i ( mem_index[b] ),
      .wdata_i ( mem_wdata[b] ),
      .rdata_o ( mem_rdata[b] )
    );
  end

  ecc_err_manager i_err_manager (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .err_i        ( bank_err     ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o )
  );

endmodule

//--- verif/ecc_interconnect_tb.sv
/*
  Self-checking testbench for the SECDED memory subsystem.
  Run from the project root; stimulus is read from verif/ecc_ic_input.txt.
  Assumes N_INIT is 2, so a dual read pairs an initiator with the other one.
  Read data is checked against a local memory model. The error kind of a read
  follows the popcount of the fault mask used when the word was written.
*/

`timescale 1ns/1ps
`include "ecc_ic_defs.svh"

module ecc_interconnect_tb;
  import ecc_ic_pkg::*;

  localparam int TIMEOUT = 50;               // Cycles allowed per wait
  localparam int DEPTH   = 1 << `AW;

  logic               clk_i;
  logic               arst_n_i;
  tcdm_req_t          init_req [`N_INIT];
  tcdm_rsp_t          init_rsp [`N_INIT];
  fault_t             fault;
  periph_req_t        periph_req;
  periph_rsp_t        periph_rsp;

  logic [`DW-1:0]     model_mem   [DEPTH];   // Last data written per address
  int                 model_flips [DEPTH];   // Flipped bits stored with it
  logic [`CNT_W-1:0]  corr_cnt    [`N_MEM];  // Expected counters
  logic [`CNT_W-1:0]  unc_cnt     [`N_MEM];

  logic [`N_INIT-1:0] op_act;                // Initiators taking part
  logic [`N_INIT-1:0] op_rd;
  logic [`AW-1:0]     op_addr [`N_INIT];
  logic [`DW-1:0]     op_data [`N_INIT];
  tcdm_rsp_t          rsp_cap [`N_INIT];     // Response caught with r_valid
  int                 gnt_cyc [`N_INIT];
  int                 rv_cyc  [`N_INIT];

  logic [15:0]        lfsr_q;
  int                 data_errs;
  int                 reg_errs;
  int                 other_errs;

  ecc_interconnect dut_i (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .init_req_i   ( init_req   ),
    .init_rsp_o   ( init_rsp   ),
    .fault_i      ( fault      ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;              // 100 ns period
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_q = lfsr_next(lfsr_q);            // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_rsp(input tcdm_rsp_t rsp, input logic [`DW-1:0] exp, input string what);
    if (!rsp.r_valid || rsp.r_data !== exp) begin
      data_errs++;
      $display("FAILED at %0t ns: %s returned %h, expected %h", $time, what, rsp.r_data, exp);
    end
  endtask

  task automatic check_reg(input periph_rsp_t rsp, input logic [`CNT_W-1:0] exp,
                           input string what);
    if (!rsp.r_valid || rsp.r_data !== exp) begin
      reg_errs++;
      $display("FAILED at %0t ns: %s returned %0d, expected %0d", $time, what, rsp.r_data, exp);
    end
  endtask

  // Present requests, hold until gnt, then collect read data
  task automatic drive_ops();
    logic [`N_INIT-1:0] need_g;
    logic [`N_INIT-1:0] need_r;
    int                 cyc;
    need_g = op_act;
    need_r = op_act & op_rd;
    for (int n = 0; n < `N_INIT; n++) begin
      gnt_cyc[n] = -1;
      rv_cyc[n]  = -1;
      rsp_cap[n] = '0;
      if (op_act[n]) begin
        init_req[n] = '{req: 1'b1, wen: op_rd[n], addr: op_addr[n], data: op_data[n]};
      end
    end
    cyc = 0;
    while ((need_g | need_r) != '0 && cyc < TIMEOUT) begin
      @(posedge clk_i);
      for (int n = 0; n < `N_INIT; n++) begin
        if (need_g[n] && init_rsp[n].gnt) begin
          need_g[n]  = 1'b0;
          gnt_cyc[n] = cyc;
        end else if (!need_g[n] && need_r[n] && init_rsp[n].r_valid) begin
          need_r[n]  = 1'b0;
          rv_cyc[n]  = cyc;
          rsp_cap[n] = init_rsp[n];
        end
      end
      @(negedge clk_i);
      for (int n = 0; n < `N_INIT; n++) begin
        if (!need_g[n]) init_req[n].req = 1'b0; // Granted, release
      end
      cyc++;
    end
    if ((need_g | need_r) != '0) begin
      other_errs++;
      $display("Timeout: gnt or r_valid not seen within %0d cycles", TIMEOUT);
    end
    for (int n = 0; n < `N_INIT; n++) init_req[n] = '0;
  endtask

  task automatic check_read(input int n);
    logic [`AW-1:0] a;
    int             b;
    a = op_addr[n];
    b = int'(a[`BANK_W-1:0]);
    if (rv_cyc[n] != gnt_cyc[n] + 1) begin
      other_errs++;
      $display("FAILED at %0t ns: initiator %0d gnt in cycle %0d but r_valid in cycle %0d",
               $time, n, gnt_cyc[n], rv_cyc[n]);
    end
    if (model_flips[a] == 1 && corr_cnt[b] != '1) corr_cnt[b]++; // Single flip corrected
    if (model_flips[a] >= 2) begin
      if (unc_cnt[b] != '1) unc_cnt[b]++;    // Data is garbage, not checked
    end else begin
      check_rsp(rsp_cap[n], model_mem[a], $sformatf("read by initiator %0d at %h", n, a));
    end
  endtask

  task automatic single_write(input int n, input logic [`AW-1:0] a, input logic [`DW-1:0] d,
                              input logic [`CW-1:0] mask);
    op_act     = '0;
    op_rd      = '0;
    op_act[n]  = 1'b1;
    op_addr[n] = a;
    op_data[n] = d;
    fault      = '{en: (mask != '0), bank: a[`BANK_W-1:0], mask: mask}; // Level during grant
    drive_ops();
    fault          = '0;
    model_mem[a]   = d;
    model_flips[a] = $countones(mask);
  endtask

  task automatic single_read(input int n, input logic [`AW-1:0] a);
    op_act     = '0;
    op_rd      = '0;
    op_act[n]  = 1'b1;
    op_rd[n]   = 1'b1;
    op_addr[n] = a;
    op_data[n] = '0;
    drive_ops();
    check_read(n);
  endtask

  task automatic dual_read(input int n, input logic [`AW-1:0] a0, input logic [`AW-1:0] a1);
    int m;
    m          = 1 - n;
    op_act     = '1;
    op_rd      = '1;
    op_addr[n] = a0;
    op_addr[m] = a1;
    op_data[n] = '0;
    op_data[m] = '0;
    drive_ops();
    check_read(n);
    check_read(m);
    if (a0[`BANK_W-1:0] == a1[`BANK_W-1:0]) begin
      if (gnt_cyc[n] == gnt_cyc[m] || gnt_cyc[n] >= `N_INIT || gnt_cyc[m] >= `N_INIT) begin
        other_errs++;
        $display("FAILED at %0t ns: same-bank grants in cycles %0d and %0d", $time,
                 gnt_cyc[n], gnt_cyc[m]);
      end
    end else if (gnt_cyc[n] != gnt_cyc[m]) begin
      other_errs++;
      $display("FAILED at %0t ns: different banks granted in cycles %0d and %0d", $time,
               gnt_cyc[n], gnt_cyc[m]);
    end
  endtask

  function automatic logic [`CNT_W-1:0] expected_count(input int ra);
    return (ra >= `N_MEM) ? unc_cnt[ra % `N_MEM] : corr_cnt[ra % `N_MEM];
  endfunction

  // wen high reads, low clears and answers zero
  task automatic reg_op(input logic is_read, input int ra);
    periph_rsp_t       rsp;
    logic [`CNT_W-1:0] exp;
    int                cyc;
    logic              got;
    if (is_read) begin
      exp = expected_count(ra);
    end else begin
      exp = '0;
      if (ra >= `N_MEM) unc_cnt[ra % `N_MEM] = '0;
      else corr_cnt[ra % `N_MEM] = '0;
    end
    periph_req = '{req: 1'b1, wen: is_read, addr: ra[`PAW-1:0]};
    @(posedge clk_i);
    @(negedge clk_i);
    periph_req = '0;
    rsp        = '0;
    got        = 1'b0;
    cyc        = 0;
    while (!got && cyc < TIMEOUT) begin
      @(posedge clk_i);
      if (periph_rsp.r_valid) begin
        got = 1'b1;
        rsp = periph_rsp;
      end
      cyc++;
    end
    @(negedge clk_i);
    if (!got) begin
      other_errs++;
      $display("Timeout: register r_valid not seen within %0d cycles", TIMEOUT);
    end else begin
      check_reg(rsp, exp, $sformatf("register %0d %s", ra, is_read ? "read" : "clear"));
    end
  endtask

  initial begin : main
    int                fd;
    string             op;
    string             line;
    int                f_init;
    logic [`AW-1:0]    f_addr;
    logic [`DW-1:0]    f_data;
    logic [`CW-1:0]    f_mask;
    logic [`DW-1:0]    f_exp;
    logic [31:0]       r;
    logic [`AW-1:0]    ra;
    int                n;
    data_errs  = 0;
    reg_errs   = 0;
    other_errs = 0;
    lfsr_q     = 16'd52428;
    arst_n_i   = 1'b0;
    fault      = '0;
    periph_req = '0;
    for (int i = 0; i < `N_INIT; i++) init_req[i] = '0;
    for (int i = 0; i < DEPTH; i++) model_flips[i] = 0;
    for (int b = 0; b < `N_MEM; b++) begin
      corr_cnt[b] = '0;
      unc_cnt[b]  = '0;
    end
    repeat (16) @(posedge clk_i);            // Reset held 16 cycles
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    fd = $fopen("verif/ecc_ic_input.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Could not open the stimulus file verif/ecc_ic_input.txt");
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.substr(0, 0) == "#") begin
          void'($fgets(line, fd));           // Comment line
        end else if ($fscanf(fd, "%d %h %h %h %h", f_init, f_addr, f_data, f_mask, f_exp) != 5) begin
          other_errs++;
          $display("Stimulus line starting with %s has missing fields", op);
          break;
        end else if (op == "wr") begin
          single_write(f_init, f_addr, f_data, f_mask);
        end else if (op == "rd") begin
          if (model_flips[f_addr] < 2 && model_mem[f_addr] !== f_exp) begin
            other_errs++;
            $display("Stimulus expects %h at %h but the model holds %h", f_exp, f_addr,
                     model_mem[f_addr]);
          end
          single_read(f_init, f_addr);
        end else if (op == "rd2") begin
          dual_read(f_init, f_addr, f_data[`AW-1:0]); // Data column is the other address
        end else if (op == "rrd" || op == "rclr") begin
          if ((op == "rrd" ? expected_count(int'(f_addr)) : '0) !== f_exp[`CNT_W-1:0]) begin
            other_errs++;
            $display("Stimulus expects %0d from register %0d, model disagrees", f_exp, f_addr);
          end
          reg_op(op == "rrd", int'(f_addr));
        end else begin
          other_errs++;
          $display("Unknown stimulus operation %s", op);
        end
      end
      $fclose(fd);
    end

    // Error-free random traffic
    for (int i = 0; i < 32; i++) begin
      draw_bits(1, r);
      n = int'(r[0]);
      draw_bits(`AW, r);
      ra = r[`AW-1:0];
      draw_bits(`DW, r);
      single_write(n, ra, r, '0);
      single_read(n, ra);
    end
    for (int i = 0; i < 2 * `N_MEM; i++) reg_op(1'b1, i); // All counters back to model

    $display("Errors: data %0d, register %0d, other %0d", data_errs, reg_errs, other_errs);
    if (data_errs + reg_errs + other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verif/ecc_ic_input.txt
# op init addr data mask exp  (init decimal, rest hex, mask is the 39-bit flip pattern)
# rd2 puts the second initiator's address in the data column; rrd/rclr use addr as register
wr   0 00 11110000 0000000000 00000000
wr   0 01 22220001 0000000000 00000000
wr   0 02 33330002 0000000000 00000000
wr   0 03 44440003 0000000000 00000000
wr   1 14 5555aaaa 0000000000 00000000
wr   1 15 6666bbbb 0000000000 00000000
wr   1 16 7777cccc 0000000000 00000000
wr   1 17 8888dddd 0000000000 00000000
rd   0 00 00000000 0000000000 11110000
rd   0 01 00000000 0000000000 22220001
rd   0 02 00000000 0000000000 33330002
rd   0 03 00000000 0000000000 44440003
rd   1 14 00000000 0000000000 5555aaaa
rd   1 15 00000000 0000000000 6666bbbb
rd   1 16 00000000 0000000000 7777cccc
rd   1 17 00000000 0000000000 8888dddd
wr   0 08 a5a5a5a5 0000000001 00000000
rd   1 08 00000000 0000000000 a5a5a5a5
rrd  0 00 00000000 0000000000 00000001
wr   1 0d deadbeef 0800000000 00000000
rd   0 0d 00000000 0000000000 deadbeef
rrd  0 01 00000000 0000000000 00000001
wr   0 0e cafef00d 0000000003 00000000
rd   0 0e 00000000 0000000000 00000000
rrd  0 06 00000000 0000000000 00000001
rrd  0 02 00000000 0000000000 00000000
rd2  0 00 00000014 0000000000 00000000
rd2  1 01 00000016 0000000000 00000000
rclr 0 00 00000000 0000000000 00000000
rrd  0 00 00000000 0000000000 00000000
rrd  0 01 00000000 0000000000 00000001
rclr 0 01 00000000 0000000000 00000000
rclr 0 06 00000000 0000000000 00000000
rrd  0 06 00000000 0000000000 00000000

//--- compile.f
+incdir+hdl
hdl/ecc_ic_pkg.sv
hdl/ecc_log_xbar.sv
hdl/ecc_bank_codec.sv
hdl/ecc_sram_bank.sv
hdl/ecc_err_manager.sv
hdl/ecc_interconnect.sv
verif/ecc_interconnect_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ECC interconnect testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module ecc_interconnect_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vecc_interconnect_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
